// ==== flist.f ====
hdl/stat_pkg.sv
hdl/stat_fwd_if.sv
hdl/stat_cycle_counters.sv
hdl/stat_snoop.sv
hdl/stat_rec_fifo.sv
hdl/stat_wb_regs.sv
hdl/stat_snoop_top.sv
test/stat_snoop_sva.sv
test/stat_snoop_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the stat snoop testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module stat_snoop_tb -f flist.f -o stat_snoop_sim

out=$(./obj_dir/stat_snoop_sim 2>&1 || true)
printf '%s\n' "$out"

# the run passes only if the testbench printed its pass line
printf '%s\n' "$out" | grep -qx '>>> PASS'

// ==== test/stat_snoop_tb.sv ====
`default_nettype none

module stat_snoop_tb;

  localparam int random_cycles   = 300;
  localparam int overflow_events = 12;
  localparam int min_burst       = 4;
  localparam int max_burst       = 16;
  // one status read per drain step, then cycle, src, tag and pop for each record
  localparam int drain_accesses  = 1 + 5 * stat_pkg::fifo_depth;
  // reset checks 11, end of the random run 9, overflow 6 plus its drain, final checks 9
  localparam int fixed_accesses  = 35 + drain_accesses;
  localparam int access_budget   = (random_cycles + min_burst - 1) / min_burst * drain_accesses
                                   + fixed_accesses;

  logic                              clk_i = 1'b0;
  logic                              rst_i;
  logic                              fwd_v_i;
  logic                              fwd_ready_i;
  logic [stat_pkg::addr_width-1:0]   fwd_addr_i;
  logic [stat_pkg::data_width-1:0]   fwd_data_i;
  logic [stat_pkg::x_cord_width-1:0] fwd_src_x_i;
  logic [stat_pkg::y_cord_width-1:0] fwd_src_y_i;
  logic                              wb_cyc_i;
  logic                              wb_stb_i;
  logic                              wb_we_i;
  logic [2:0]                        wb_adr_i;
  logic [31:0]                       wb_dat_i;
  logic [31:0]                       wb_dat_o;
  logic                              wb_ack_o;
  logic                              stat_v_o;
  logic [stat_pkg::data_width-1:0]   stat_tag_o;

  // reference model state
  stat_pkg::stat_rec_t exp_q [$];
  logic [15:0]         exp_drops;
  logic [31:0]         exp_kind_cnt [4];
  logic [31:0]         model_cycle; // counter value of the current cycle
  logic                exp_ack = 1'b0;
  int                  reset_edges = 0;

  stat_snoop_top i_dut (.*);

  always #4 clk_i = ~clk_i;

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // the model follows every edge, the link and the bus alike
  always @(posedge clk_i) begin : model_update
    logic                hit;
    logic                full;
    logic                empty;
    logic                wr_ack;
    stat_pkg::stat_rec_t rec;
    hit = fwd_v_i && fwd_ready_i && (fwd_addr_i == stat_pkg::print_stat_epa);
    check_eq("stat_v_o", {31'b0, hit}, {31'b0, stat_v_o});
    check_eq("stat_tag_o", hit ? fwd_data_i : 32'd0, stat_tag_o);
    if (rst_i) begin
      // the ack state is only defined once a reset edge has passed
      if (reset_edges > 0) check_eq("wb_ack_o in reset", 32'd0, {31'b0, wb_ack_o});
      reset_edges++;
      exp_q.delete();
      exp_drops = '0;
      for (int k = 0; k < 4; k++) begin
        exp_kind_cnt[k] = '0;
      end
      exp_ack = 1'b0;
      model_cycle <= '0;
    end else begin
      check_eq("wb_ack_o", {31'b0, exp_ack}, {31'b0, wb_ack_o});
      full   = (exp_q.size() == stat_pkg::fifo_depth);
      empty  = (exp_q.size() == 0);
      wr_ack = exp_ack && wb_cyc_i && wb_stb_i && wb_we_i;
      if (hit) begin
        exp_kind_cnt[fwd_data_i[31:30]] += 32'd1;
        rec.cycle = model_cycle;
        rec.src_y = fwd_src_y_i;
        rec.src_x = fwd_src_x_i;
        rec.tag   = stat_pkg::stat_tag_t'(fwd_data_i);
        if (!full) exp_q.push_back(rec);
        else if (exp_drops != 16'hffff) exp_drops++;
      end
      if (wr_ack && wb_adr_i == stat_pkg::reg_pop && !empty) void'(exp_q.pop_front());
      if (wr_ack && wb_adr_i == stat_pkg::reg_drops) exp_drops = '0;
      exp_ack = !exp_ack && wb_cyc_i && wb_stb_i; // ack follows the first request cycle
      model_cycle <= model_cycle + 32'd1;
    end
  end

  initial begin : watchdog
    repeat ((random_cycles + overflow_events + access_budget) * 20) @(posedge clk_i);
    $display("timeout: the run did not finish within the expected number of cycles");
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  // called at a rising edge, returns at the edge after the ack edge
  task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic [31:0] ack_cycle);
    int edges;
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= wdata;
    edges = 0;
    do begin
      @(posedge clk_i);
      edges++;
    end while (!wb_ack_o && edges < 8);
    check_eq("edges from stb to ack", 32'd2, edges);
    rdata     = wb_dat_o;
    ack_cycle = model_cycle;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic write_reg(input logic [2:0] adr, input logic [31:0] wdata);
    logic [31:0] ignored_data;
    logic [31:0] ignored_cycle;
    bus_access(1'b1, adr, wdata, ignored_data, ignored_cycle);
  endtask

  task automatic expect_reg(input string name, input logic [2:0] adr,
                            input logic [31:0] expected);
    logic [31:0] rdata;
    logic [31:0] ack_cycle;
    bus_access(1'b0, adr, 32'd0, rdata, ack_cycle);
    check_eq(name, expected, rdata);
  endtask

  task automatic check_now();
    logic [31:0] rdata;
    logic [31:0] ack_cycle;
    bus_access(1'b0, stat_pkg::reg_now, 32'd0, rdata, ack_cycle);
    check_eq("reg_now", ack_cycle, rdata);
  endtask

  function automatic logic [31:0] status_word(input int level);
    logic [31:0] word;
    word = 32'(level);
    word[stat_pkg::status_empty_bit] = (level == 0);
    return word;
  endfunction

  task automatic drain_fifo(input string name);
    stat_pkg::stat_rec_t head;
    for (int i = 0; i <= stat_pkg::fifo_depth; i++) begin
      expect_reg({name, " status"}, stat_pkg::reg_status, status_word(exp_q.size()));
      if (exp_q.size() == 0) break;
      head = exp_q[0];
      expect_reg({name, " cycle"}, stat_pkg::reg_cycle, head.cycle);
      expect_reg({name, " src"}, stat_pkg::reg_src, {24'b0, head.src_y, head.src_x});
      expect_reg({name, " tag"}, stat_pkg::reg_tag, head.tag);
      write_reg(stat_pkg::reg_pop, 32'd0);
    end
  endtask

  task automatic check_kind_counts(input string name);
    for (int k = 0; k < 4; k++) begin
      write_reg(stat_pkg::reg_kind_cnt, 32'(k));
      expect_reg($sformatf("%s kind %0d", name, k), stat_pkg::reg_kind_cnt, exp_kind_cnt[k]);
    end
  endtask

  // all_stat forces an accepted print-stat packet in every cycle
  task automatic drive_link(input int cycles, input logic all_stat);
    repeat (cycles) begin
      @(posedge clk_i);
      fwd_v_i     <= all_stat | 1'($urandom_range(0, 1));
      fwd_ready_i <= all_stat | ($urandom_range(0, 3) != 0);
      fwd_addr_i  <= (all_stat || $urandom_range(0, 1) == 1) ?
                     stat_pkg::print_stat_epa : 16'($urandom);
      fwd_data_i  <= $urandom;
      fwd_src_x_i <= 4'($urandom);
      fwd_src_y_i <= 4'($urandom);
    end
    @(posedge clk_i);
    fwd_v_i     <= 1'b0;
    fwd_ready_i <= 1'b0;
    @(posedge clk_i);
  endtask

  initial begin : main
    int done;
    int len;
    void'($urandom(73));
    rst_i       = 1'b1;
    fwd_v_i     = 1'b0;
    fwd_ready_i = 1'b0;
    fwd_addr_i  = '0;
    fwd_data_i  = '0;
    fwd_src_x_i = '0;
    fwd_src_y_i = '0;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_adr_i    = '0;
    wb_dat_i    = '0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    expect_reg("reset status", stat_pkg::reg_status, status_word(0));
    expect_reg("reset drops", stat_pkg::reg_drops, 32'd0);
    check_kind_counts("reset");
    check_now();

    done = 0;
    while (done < random_cycles) begin
      len = $urandom_range(min_burst, max_burst);
      if (len > random_cycles - done) len = random_cycles - done;
      drive_link(len, 1'b0);
      drain_fifo("capture");
      done += len;
    end
    expect_reg("random drops", stat_pkg::reg_drops, 32'(exp_drops));
    check_kind_counts("random");

    write_reg(stat_pkg::reg_drops, 32'd0);
    expect_reg("drops before overflow", stat_pkg::reg_drops, 32'd0);
    drive_link(overflow_events, 1'b1);
    expect_reg("overflow status", stat_pkg::reg_status, status_word(stat_pkg::fifo_depth));
    expect_reg("overflow drops", stat_pkg::reg_drops, 32'(overflow_events - stat_pkg::fifo_depth));
    write_reg(stat_pkg::reg_drops, 32'd0);
    expect_reg("drops after clear", stat_pkg::reg_drops, 32'd0);
    drain_fifo("overflow");
    check_kind_counts("final");
    check_now();

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/stat_snoop_sva.sv ====
`default_nettype none

module stat_snoop_sva (
  input logic                              clk_i,
  input logic                              rst_i,
  input logic                              wb_cyc_i,
  input logic                              wb_stb_i,
  input logic                              wb_ack_i,
  input logic [stat_pkg::fifo_ptr_width:0] level_i
);

  property ack_one_cycle;
    @(posedge clk_i) disable iff (rst_i) wb_ack_i |=> !wb_ack_i;
  endproperty

  // the slave only answers a request it has seen
  property ack_after_request;
    @(posedge clk_i) disable iff (rst_i) wb_ack_i |-> $past(wb_cyc_i && wb_stb_i);
  endproperty

  property level_in_range;
    @(posedge clk_i) disable iff (rst_i) level_i <= stat_pkg::fifo_depth;
  endproperty

  assert_ack_one_cycle: assert property (ack_one_cycle)
    else $error("wb_ack_o high for two cycles in a row");

  assert_ack_after_request: assert property (ack_after_request)
    else $error("wb_ack_o without a preceding cyc and stb");

  assert_level_in_range: assert property (level_in_range)
    else $error("fifo level above its depth");

endmodule

bind stat_wb_regs stat_snoop_sva i_sva (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_ack_i (wb_ack_o),
  .level_i  (level_i)
);

`default_nettype wire

// ==== hdl/stat_snoop_top.sv ====
`default_nettype none

module stat_snoop_top (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // observed forward link
  input  logic                              fwd_v_i,
  input  logic                              fwd_ready_i,
  input  logic [stat_pkg::addr_width-1:0]   fwd_addr_i,
  input  logic [stat_pkg::data_width-1:0]   fwd_data_i,
  input  logic [stat_pkg::x_cord_width-1:0] fwd_src_x_i,
  input  logic [stat_pkg::y_cord_width-1:0] fwd_src_y_i,
  // wishbone classic slave
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [2:0]                        wb_adr_i,
  input  logic [31:0]                       wb_dat_i,
  output logic [31:0]                       wb_dat_o,
  output logic                              wb_ack_o,
  // stat event strobe
  output logic                              stat_v_o,
  output logic [stat_pkg::data_width-1:0]   stat_tag_o
);

  stat_fwd_if fwd ();

  logic                              snoop_push;
  stat_pkg::stat_rec_t               snoop_rec;
  logic                              snoop_event;
  stat_pkg::stat_kind_e              snoop_kind;
  logic [31:0]                       cycle;
  logic [31:0]                       kind_cnt;
  logic [1:0]                        kind_sel;
  stat_pkg::stat_rec_t               head;
  logic [stat_pkg::fifo_ptr_width:0] level;
  logic                              empty;
  logic [15:0]                       drops;
  logic                              pop;
  logic                              clr_drops;

  assign fwd.fwd_v     = fwd_v_i;
  assign fwd.fwd_ready = fwd_ready_i;
  assign fwd.fwd_addr  = fwd_addr_i;
  assign fwd.fwd_data  = fwd_data_i;
  assign fwd.fwd_src_x = fwd_src_x_i;
  assign fwd.fwd_src_y = fwd_src_y_i;

  stat_snoop i_snoop (
    .fwd     (fwd.snoop),
    .cycle_i (cycle),
    .push_o  (snoop_push),
    .rec_o   (snoop_rec),
    .event_o (snoop_event),
    .kind_o  (snoop_kind),
    .tag_o   (stat_tag_o)
  );

  assign stat_v_o = snoop_event;

  stat_cycle_counters i_counters (
    .clk_i, .rst_i,
    .event_i    (snoop_event),
    .kind_i     (snoop_kind),
    .kind_sel_i (kind_sel),
    .cycle_o    (cycle),
    .kind_cnt_o (kind_cnt)
  );

  stat_rec_fifo i_fifo (
    .clk_i, .rst_i,
    .push_i      (snoop_push),
    .rec_i       (snoop_rec),
    .pop_i       (pop),
    .clr_drops_i (clr_drops),
    .head_o      (head),
    .level_o     (level),
    .empty_o     (empty),
    .drops_o     (drops)
  );

  stat_wb_regs i_regs (
    .clk_i, .rst_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .head_i      (head),
    .level_i     (level),
    .empty_i     (empty),
    .drops_i     (drops),
    .cycle_i     (cycle),
    .kind_cnt_i  (kind_cnt),
    .pop_o       (pop),
    .clr_drops_o (clr_drops),
    .kind_sel_o  (kind_sel)
  );

endmodule

`default_nettype wire

// ==== hdl/stat_wb_regs.sv ====
`default_nettype none

module stat_wb_regs (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [2:0]                        wb_adr_i,
  input  logic [31:0]                       wb_dat_i,
  output logic [31:0]                       wb_dat_o,
  output logic                              wb_ack_o,
  input  stat_pkg::stat_rec_t               head_i,
  input  logic [stat_pkg::fifo_ptr_width:0] level_i,
  input  logic                              empty_i,
  input  logic [15:0]                       drops_i,
  input  logic [31:0]                       cycle_i,
  input  logic [31:0]                       kind_cnt_i,
  output logic                              pop_o,
  output logic                              clr_drops_o,
  output logic [1:0]                        kind_sel_o
);

  typedef enum logic {
    st_idle,
    st_ack
  } state_e;

  state_e      state_q;
  logic        req;
  logic        wr_ack;
  logic [31:0] rd_mux;
  logic [31:0] rd_data_q;
  logic [1:0]  kind_sel_q;

  assign req = wb_cyc_i & wb_stb_i;

  // one ack per request, then back to idle until stb shows up again
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: if (req) state_q <= st_ack;
        st_ack:  state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  assign wb_ack_o = (state_q == st_ack);

  // the master holds address and data until ack, so the ack cycle sees them
  assign wr_ack = wb_ack_o & req & wb_we_i;

  assign pop_o       = wr_ack & (wb_adr_i == stat_pkg::reg_pop);
  assign clr_drops_o = wr_ack & (wb_adr_i == stat_pkg::reg_drops);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      kind_sel_q <= '0;
    end else if (wr_ack && wb_adr_i == stat_pkg::reg_kind_cnt) begin
      kind_sel_q <= wb_dat_i[1:0];
    end
  end

  assign kind_sel_o = kind_sel_q;

  always_comb begin
    rd_mux = '0;
    case (wb_adr_i)
      stat_pkg::reg_status: begin
        rd_mux[stat_pkg::fifo_ptr_width:0]  = level_i;
        rd_mux[stat_pkg::status_empty_bit] = empty_i;
      end
      stat_pkg::reg_cycle:    rd_mux = head_i.cycle;
      stat_pkg::reg_src:      rd_mux = {24'b0, head_i.src_y, head_i.src_x};
      stat_pkg::reg_tag:      rd_mux = head_i.tag;
      stat_pkg::reg_drops:    rd_mux = {16'b0, drops_i};
      stat_pkg::reg_kind_cnt: rd_mux = kind_cnt_i;
      // value the counter holds while ack is up
      stat_pkg::reg_now:      rd_mux = cycle_i + 32'd1;
      default:                rd_mux = '0; // pop is write only
    endcase
  end

  // read data is sampled when the request is first seen
  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && req) begin
      rd_data_q <= rd_mux;
    end
  end

  assign wb_dat_o = rd_data_q;

endmodule

`default_nettype wire

// ==== hdl/stat_rec_fifo.sv ====
`default_nettype none

module stat_rec_fifo (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                push_i,
  input  stat_pkg::stat_rec_t                 rec_i,
  input  logic                                pop_i,
  input  logic                                clr_drops_i,
  output stat_pkg::stat_rec_t                 head_o,
  output logic [stat_pkg::fifo_ptr_width:0]   level_o,
  output logic                                empty_o,
  output logic [15:0]                         drops_o
);

  stat_pkg::stat_rec_t mem_q [stat_pkg::fifo_depth];

  logic [stat_pkg::fifo_ptr_width-1:0] wr_ptr_q;
  logic [stat_pkg::fifo_ptr_width-1:0] rd_ptr_q;
  logic [stat_pkg::fifo_ptr_width:0]   count_q;
  logic [15:0]                         drops_q;
  logic                                full;
  logic                                do_push;
  logic                                do_pop;

  assign full    = (count_q == stat_pkg::fifo_depth);
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty_o; // popping an empty fifo is ignored

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1; // pointers wrap at the depth
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + {3'b0, do_push} - {3'b0, do_pop};
    end
  end

  // overflow count sticks at its maximum until the host clears it
  always_ff @(posedge clk_i) begin
    if (rst_i || clr_drops_i) begin
      drops_q <= '0;
    end else if (push_i && full && drops_q != 16'hffff) begin
      drops_q <= drops_q + 16'd1;
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign level_o = count_q;
  assign drops_o = drops_q;

endmodule

`default_nettype wire

// ==== hdl/stat_snoop.sv ====
`default_nettype none

module stat_snoop (
  stat_fwd_if.snoop                       fwd,
  input  logic [31:0]                     cycle_i,
  output logic                            push_o,
  output stat_pkg::stat_rec_t             rec_o,
  output logic                            event_o,
  output stat_pkg::stat_kind_e            kind_o,
  output logic [stat_pkg::data_width-1:0] tag_o
);

  logic                xfer;
  logic                hit;
  stat_pkg::stat_tag_t payload_tag;

  // a packet only moves when the host accepts it
  assign xfer = fwd.fwd_v & fwd.fwd_ready;
  assign hit  = xfer & (fwd.fwd_addr == stat_pkg::print_stat_epa);

  assign payload_tag = stat_pkg::stat_tag_t'(fwd.fwd_data);

  always_comb begin
    rec_o.cycle = cycle_i; // time of the transfer edge
    rec_o.src_y = fwd.fwd_src_y;
    rec_o.src_x = fwd.fwd_src_x;
    rec_o.tag   = payload_tag;
  end

  // fifo and counters see the same decision
  assign push_o  = hit;
  assign event_o = hit;
  assign kind_o  = payload_tag.kind;

  // the tag is only meaningful alongside an event
  assign tag_o = hit ? fwd.fwd_data : '0;

endmodule

`default_nettype wire

// ==== hdl/stat_cycle_counters.sv ====
`default_nettype none

module stat_cycle_counters (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  event_i,
  input  stat_pkg::stat_kind_e  kind_i,
  input  logic [1:0]            kind_sel_i,
  output logic [31:0]           cycle_o,
  output logic [31:0]           kind_cnt_o
);

  logic [31:0] cycle_q;
  logic [31:0] kind_cnt_q [4];

  // global time base, zero in the first cycle out of reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 32'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 4; i++) begin
        kind_cnt_q[i] <= '0;
      end
    end else if (event_i) begin
      // counts every stat event, whether or not the fifo kept the record
      kind_cnt_q[kind_i] <= kind_cnt_q[kind_i] + 32'd1;
    end
  end

  assign cycle_o    = cycle_q;
  assign kind_cnt_o = kind_cnt_q[kind_sel_i]; // host picks one counter at a time

endmodule

`default_nettype wire

// ==== hdl/stat_fwd_if.sv ====
`default_nettype none

interface stat_fwd_if;

  logic                              fwd_v;
  logic                              fwd_ready; // host side acceptance
  logic [stat_pkg::addr_width-1:0]   fwd_addr;
  logic [stat_pkg::data_width-1:0]   fwd_data;
  logic [stat_pkg::x_cord_width-1:0] fwd_src_x;
  logic [stat_pkg::y_cord_width-1:0] fwd_src_y;

  modport src (
    output fwd_v,
    output fwd_ready,
    output fwd_addr,
    output fwd_data,
    output fwd_src_x,
    output fwd_src_y
  );

  // the snoop side never drives anything back onto the link
  modport snoop (
    input fwd_v,
    input fwd_ready,
    input fwd_addr,
    input fwd_data,
    input fwd_src_x,
    input fwd_src_y
  );

endinterface

`default_nettype wire

// ==== hdl/stat_pkg.sv ====
`default_nettype none

package stat_pkg;

  // observed forward link
  localparam int addr_width   = 16;
  localparam int data_width   = 32;
  localparam int x_cord_width = 4;
  localparam int y_cord_width = 4;

  // word address of the print-stat endpoint (byte address 0x0d0c >> 2)
  localparam logic [addr_width-1:0] print_stat_epa = 16'h0343;

  typedef enum logic [1:0] {
    e_stat           = 2'd0,
    e_kernel_start   = 2'd1,
    e_kernel_end     = 2'd2,
    e_tile_group_end = 2'd3
  } stat_kind_e;

  // layout of the payload word of a stat packet
  typedef struct packed {
    stat_kind_e  kind;
    logic [13:0] tg_id;
    logic [15:0] tag;
  } stat_tag_t;

  typedef struct packed {
    logic [31:0]             cycle;
    logic [y_cord_width-1:0] src_y;
    logic [x_cord_width-1:0] src_x;
    stat_tag_t               tag;
  } stat_rec_t;

  localparam int fifo_depth     = 8;
  localparam int fifo_ptr_width = 3;

  // reg_status holds the level in the low bits and the empty flag here
  localparam int status_empty_bit = 4;

  // wishbone word offsets
  localparam logic [2:0] reg_status   = 3'd0;
  localparam logic [2:0] reg_cycle    = 3'd1;
  localparam logic [2:0] reg_src      = 3'd2;
  localparam logic [2:0] reg_tag      = 3'd3;
  localparam logic [2:0] reg_drops    = 3'd4;
  localparam logic [2:0] reg_pop      = 3'd5;
  localparam logic [2:0] reg_kind_cnt = 3'd6;
  localparam logic [2:0] reg_now      = 3'd7;

endpackage

`default_nettype wire
